// File: rtl/pixel_pkg.sv
package pixel_pkg;

  // Stream geometry
  localparam int word_width  = 8;
  localparam int rows        = 4;
  localparam int kh_max      = 3;
  localparam int edge_words  = kh_max / 2;
  localparam int in_words    = rows + edge_words;
  localparam int shift_words = rows + 2 * edge_words;

  // Frame limits
  localparam int cin_max    = 4;
  localparam int cols_max   = 8;
  localparam int blocks_max = 4;
  localparam int edge_depth = cin_max * cols_max;

  // Counter and field widths
  localparam int kh2_bits       = $clog2(edge_words + 1);
  localparam int step_bits      = kh2_bits + 1;
  localparam int ci_bits        = $clog2(cin_max);
  localparam int col_bits       = $clog2(cols_max);
  localparam int blk_bits       = $clog2(blocks_max);
  localparam int edge_addr_bits = $clog2(edge_depth);
  localparam int cfg_pad_bits   =
    in_words * word_width - kh2_bits - ci_bits - col_bits - blk_bits;

  typedef logic [word_width-1:0] pixel_word_t;
  typedef pixel_word_t [in_words-1:0] pixel_words_t;
  typedef pixel_word_t [edge_words-1:0] edge_t;
  typedef pixel_word_t [rows-1:0] out_words_t;

  // Header beat with kh2 in the low bits
  typedef struct packed {
    logic [cfg_pad_bits-1:0] pad;
    logic [blk_bits-1:0]     blk_last;
    logic [col_bits-1:0]     col_last;
    logic [ci_bits-1:0]      ci_last;
    logic [kh2_bits-1:0]     kh2;
  } frame_cfg_t;

  // First beat of a frame is a header and the rest are pixels
  typedef union packed {
    frame_cfg_t   cfg;
    pixel_words_t px;
  } in_beat_u;

  // Position of one pixel beat within the frame
  typedef struct packed {
    logic                      first_blk;
    logic                      last_blk;
    logic                      frame_last;
    logic [edge_addr_bits-1:0] edge_addr;
  } beat_pos_t;

endpackage

// File: rtl/pixel_frame_ctrl.sv
`timescale 1ns/100ps

module pixel_frame_ctrl (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             s_valid,
  input  logic                             s_last,
  input  pixel_pkg::in_beat_u              s_data,
  input  logic                             shift_free,
  input  logic                             m_last_beat,
  output logic                             s_ready,
  output logic                             take_beat,
  output pixel_pkg::beat_pos_t             beat_pos,
  output pixel_pkg::pixel_words_t          beat_data,
  output logic [pixel_pkg::kh2_bits-1:0]   cfg_kh2
);
  import pixel_pkg::*;

  typedef enum logic [1:0] {
    st_setup,
    st_pass,
    st_drain
  } state_t;

  state_t                    state;
  frame_cfg_t                cfg_q;
  logic [ci_bits-1:0]        ci_cnt;
  logic [col_bits-1:0]       col_cnt;
  logic [blk_bits-1:0]       blk_cnt;
  logic [edge_addr_bits-1:0] addr_cnt;
  logic                      take_cfg;
  logic                      last_ci;
  logic                      last_col;

  // Input handshake
  always_comb begin
    case (state)
      st_setup: s_ready = 1'b1;
      st_pass:  s_ready = shift_free;
      default:  s_ready = 1'b0;
    endcase
  end

  assign take_cfg  = (state == st_setup) && s_valid;
  assign take_beat = (state == st_pass) && s_valid && s_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= st_setup;
    end else begin
      case (state)
        st_setup: begin
          if (take_cfg) begin
            state <= st_pass;
          end
        end
        st_pass: begin
          if (take_beat && s_last) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          // Wait for the final output beat of the frame
          if (m_last_beat) begin
            state <= st_setup;
          end
        end
        default: state <= st_setup;
      endcase
    end
  end

  // Header fields stay fixed for the whole frame
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg_q <= '0;
    end else if (take_cfg) begin
      cfg_q <= s_data.cfg;
    end
  end

  assign cfg_kh2 = cfg_q.kh2;

  assign last_ci  = (ci_cnt == cfg_q.ci_last);
  assign last_col = (col_cnt == cfg_q.col_last);

  // Channel, then column, then block
  always_ff @(posedge aclk) begin
    if (!aresetn || state == st_setup) begin
      ci_cnt   <= '0;
      col_cnt  <= '0;
      blk_cnt  <= '0;
      addr_cnt <= '0;
    end else if (take_beat) begin
      if (last_ci) begin
        ci_cnt <= '0;
        if (last_col) begin
          col_cnt  <= '0;
          blk_cnt  <= blk_cnt + 1'b1;
          addr_cnt <= '0;
        end else begin
          col_cnt  <= col_cnt + 1'b1;
          addr_cnt <= addr_cnt + 1'b1;
        end
      end else begin
        ci_cnt   <= ci_cnt + 1'b1;
        addr_cnt <= addr_cnt + 1'b1;
      end
    end
  end

  // Position of the beat on offer is sampled by the shifter on acceptance
  always_comb begin
    beat_pos.first_blk  = (blk_cnt == '0);
    beat_pos.last_blk   = (blk_cnt == cfg_q.blk_last);
    beat_pos.frame_last = s_last;
    beat_pos.edge_addr  = addr_cnt;
  end

  // Pixel words line up with the edge memory read
  always_ff @(posedge aclk) begin
    if (take_beat) begin
      beat_data <= s_data.px;
    end
  end

endmodule

// File: rtl/edge_line_ram.sv
`timescale 1ns/100ps

module edge_line_ram (
  input  logic                                 aclk,
  input  logic                                 rd_en,
  input  logic [pixel_pkg::edge_addr_bits-1:0] rd_addr,
  input  logic                                 rd_first,
  input  logic                                 wr_en,
  input  logic [pixel_pkg::edge_addr_bits-1:0] wr_addr,
  input  pixel_pkg::edge_t                     wr_data,
  output pixel_pkg::edge_t                     top_edge
);
  import pixel_pkg::*;

  edge_t mem [edge_depth];
  edge_t rd_q;
  logic  first_q;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      first_q <= rd_first;
      // One beat per block can read the entry being written on this edge
      if (wr_en && wr_addr == rd_addr) begin
        rd_q <= wr_data;
      end else begin
        rd_q <= mem[rd_addr];
      end
    end
  end

  // Rows above the first block are zero
  assign top_edge = first_q ? '0 : rd_q;

endmodule

// File: rtl/window_shifter.sv
`timescale 1ns/100ps

module window_shifter (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic                                 take_beat,
  input  pixel_pkg::beat_pos_t                 beat_pos,
  input  pixel_pkg::pixel_words_t              beat_data,
  input  pixel_pkg::edge_t                     top_edge,
  input  logic [pixel_pkg::kh2_bits-1:0]       cfg_kh2,
  input  logic                                 m_ready,
  output logic                                 shift_free,
  output logic                                 edge_wr_en,
  output logic [pixel_pkg::edge_addr_bits-1:0] edge_wr_addr,
  output pixel_pkg::edge_t                     edge_wr_data,
  output logic                                 m_valid,
  output pixel_pkg::out_words_t                m_data,
  output logic                                 m_last
);
  import pixel_pkg::*;

  pixel_word_t [shift_words-1:0] shift_q;
  beat_pos_t                     pos_q;
  logic [step_bits-1:0]          step;
  logic                          pend;
  logic                          last_step;
  logic                          load;
  logic                          advance;
  logic                          frame_last_q;

  assign last_step = (step == {cfg_kh2, 1'b0});
  assign advance   = m_valid && m_ready;

  // Pending beat enters once the current window is done
  assign load = pend && (!m_valid || (last_step && m_ready));

  // Hold off while stalled or while the pending slot is still occupied
  assign shift_free = (!m_valid || m_ready) && (!pend || load);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pend    <= 1'b0;
      m_valid <= 1'b0;
      step    <= '0;
    end else begin
      if (take_beat) begin
        pend <= 1'b1;
      end else if (load) begin
        pend <= 1'b0;
      end

      if (load) begin
        m_valid <= 1'b1;
        step    <= '0;
      end else if (advance) begin
        if (last_step) begin
          m_valid <= 1'b0;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take_beat) begin
      pos_q <= beat_pos;
    end
  end

  // Top edge goes to the low words and one word moves down per step
  always_ff @(posedge aclk) begin
    if (load) begin
      shift_q      <= {beat_data, top_edge};
      frame_last_q <= pos_q.frame_last;
    end else if (advance) begin
      shift_q <= shift_q >> word_width;
    end
  end

  always_comb begin
    for (int r = 0; r < rows; r++) begin
      m_data[r] = shift_q[r + edge_words - int'(cfg_kh2)];
    end
  end

  assign m_last = m_valid && last_step && frame_last_q;

  // Bottom rows of this block become the top edge of the next
  assign edge_wr_en   = load && !pos_q.last_blk;
  assign edge_wr_addr = pos_q.edge_addr;
  assign edge_wr_data = beat_data[rows-1:rows-edge_words];

endmodule

// File: rtl/axis_pixels.sv
`timescale 1ns/100ps

module axis_pixels (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic                  s_last,
  input  pixel_pkg::in_beat_u   s_data,
  output logic                  m_valid,
  input  logic                  m_ready,
  output pixel_pkg::out_words_t m_data,
  output logic                  m_last
);
  import pixel_pkg::*;

  logic                      take_beat;
  logic                      shift_free;
  logic                      m_last_beat;
  logic                      edge_wr_en;
  logic [edge_addr_bits-1:0] edge_wr_addr;
  logic [kh2_bits-1:0]       cfg_kh2;
  beat_pos_t                 beat_pos;
  pixel_words_t              beat_data;
  edge_t                     top_edge;
  edge_t                     edge_wr_data;

  // Frame ends when its final output beat is taken
  assign m_last_beat = m_valid && m_ready && m_last;

  pixel_frame_ctrl ctrl0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_valid     (s_valid),
    .s_last      (s_last),
    .s_data      (s_data),
    .shift_free  (shift_free),
    .m_last_beat (m_last_beat),
    .s_ready     (s_ready),
    .take_beat   (take_beat),
    .beat_pos    (beat_pos),
    .beat_data   (beat_data),
    .cfg_kh2     (cfg_kh2)
  );

  edge_line_ram ram0 (
    .aclk     (aclk),
    .rd_en    (take_beat),
    .rd_addr  (beat_pos.edge_addr),
    .rd_first (beat_pos.first_blk),
    .wr_en    (edge_wr_en),
    .wr_addr  (edge_wr_addr),
    .wr_data  (edge_wr_data),
    .top_edge (top_edge)
  );

  window_shifter shift0 (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .take_beat    (take_beat),
    .beat_pos     (beat_pos),
    .beat_data    (beat_data),
    .top_edge     (top_edge),
    .cfg_kh2      (cfg_kh2),
    .m_ready      (m_ready),
    .shift_free   (shift_free),
    .edge_wr_en   (edge_wr_en),
    .edge_wr_addr (edge_wr_addr),
    .edge_wr_data (edge_wr_data),
    .m_valid      (m_valid),
    .m_data       (m_data),
    .m_last       (m_last)
  );

endmodule

// File: test/axis_pixels_tb.sv
`timescale 1ns/100ps

module axis_pixels_tb;
  import pixel_pkg::*;

  logic       aclk;
  logic       aresetn;
  logic       s_valid;
  logic       s_ready;
  logic       s_last;
  in_beat_u   s_data;
  logic       m_valid;
  logic       m_ready = 1'b0;
  out_words_t m_data;
  logic       m_last;

  logic [15:0]  px_lfsr = 16'd88;
  logic [15:0]  rdy_lfsr = 16'd88;
  logic         rdy_a;
  logic         ready_gaps;
  logic         gaps_on;
  pixel_words_t px_mem [blocks_max][cols_max][cin_max];
  out_words_t   exp_data [$];
  logic         exp_last [$];
  string        frame_names [$];
  int           frames_done = 0;
  logic         stalled = 1'b0;
  out_words_t   held_data;
  logic         held_last;

  axis_pixels dut0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  always #10 aclk = ~aclk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      px_lfsr = lfsr_next(px_lfsr);
      v = {v[30:0], px_lfsr[0]};
    end
  endtask

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // Offer one beat and hold it until the handshake
  task automatic send_beat(input in_beat_u data, input logic last);
    int waited;
    waited = 0;
    s_valid = 1'b1;
    s_data  = data;
    s_last  = last;
    @(negedge aclk);
    while (!s_ready) begin
      waited++;
      if (waited > 500) stop_run("s_ready stayed low while an input beat was offered");
      @(negedge aclk);
    end
    @(posedge aclk);
    #2;
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic run_frame(input string name, input logic [kh2_bits-1:0] kh2,
                           input int nblk, input int ncol, input int nch);
    in_beat_u    hdr;
    logic [31:0] bits;
    pixel_word_t v [shift_words];
    out_words_t  win;
    for (int b = 0; b < nblk; b++)
      for (int w = 0; w < ncol; w++)
        for (int c = 0; c < nch; c++)
          for (int i = 0; i < in_words; i++) begin
            draw_bits(word_width, bits);
            px_mem[b][w][c][i] = bits[word_width-1:0];
          end
    // Expected windows from the top edge below the beat words
    for (int b = 0; b < nblk; b++)
      for (int w = 0; w < ncol; w++)
        for (int c = 0; c < nch; c++) begin
          for (int e = 0; e < edge_words; e++) begin
            if (b == 0) v[e] = '0;
            else v[e] = px_mem[b-1][w][c][rows-edge_words+e];
          end
          for (int i = 0; i < in_words; i++) v[edge_words+i] = px_mem[b][w][c][i];
          for (int k = 0; k <= 2 * int'(kh2); k++) begin
            for (int r = 0; r < rows; r++) win[r] = v[r + k + edge_words - int'(kh2)];
            exp_data.push_back(win);
            exp_last.push_back(b == nblk - 1 && w == ncol - 1 && c == nch - 1 &&
                               k == 2 * int'(kh2));
          end
        end
    frame_names.push_back(name);
    hdr = '0;
    hdr.cfg.kh2      = kh2;
    hdr.cfg.ci_last  = ci_bits'(nch - 1);
    hdr.cfg.col_last = col_bits'(ncol - 1);
    hdr.cfg.blk_last = blk_bits'(nblk - 1);
    send_beat(hdr, 1'b0);
    for (int b = 0; b < nblk; b++)
      for (int w = 0; w < ncol; w++)
        for (int c = 0; c < nch; c++) begin
          hdr.px = px_mem[b][w][c];
          send_beat(hdr, b == nblk - 1 && w == ncol - 1 && c == nch - 1);
        end
  endtask

  // Output side back-pressure
  always @(posedge aclk) begin
    gaps_on = ready_gaps;
    #2;
    if (gaps_on) begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      rdy_a    = rdy_lfsr[0];
      rdy_lfsr = lfsr_next(rdy_lfsr);
      m_ready  = rdy_a | rdy_lfsr[0];
    end else begin
      m_ready = 1'b1;
    end
  end

  assert property (@(posedge aclk) disable iff (!aresetn) m_last |-> m_valid)
    else stop_run("m_last was high without m_valid");

  assert property (@(posedge aclk) disable iff (!aresetn) m_valid && !m_ready |=> m_valid)
    else stop_run("m_valid dropped while the output was stalled");

  // Outputs are sampled mid-cycle where they are settled
  always @(negedge aclk) begin
    if (aresetn) begin
      if (stalled) begin
        check_value("hold m_data", 32'(held_data), 32'(m_data));
        check_value("hold m_last", 32'(held_last), 32'(m_last));
      end
      if (m_valid && m_ready) begin
        assert (exp_data.size() > 0)
          else stop_run("the DUT sent an output beat that was not expected");
        check_value({frame_names[0], " m_data"}, 32'(exp_data[0]), 32'(m_data));
        check_value({frame_names[0], " m_last"}, 32'(exp_last[0]), 32'(m_last));
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
        if (m_last) begin
          void'(frame_names.pop_front());
          frames_done++;
        end
      end
      stalled   = m_valid && !m_ready;
      held_data = m_data;
      held_last = m_last;
    end
  end

  initial begin
    int waited;
    aclk       = 1'b0;
    aresetn    = 1'b0;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    s_data     = '0;
    ready_gaps = 1'b0;
    repeat (4) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    @(negedge aclk);
    check_value("reset m_valid", 32'd0, 32'(m_valid));
    check_value("reset m_last", 32'd0, 32'(m_last));
    check_value("reset s_ready", 32'd1, 32'(s_ready));
    @(posedge aclk);
    #2;
    run_frame("kh3_edges", 1'b1, 2, 3, 2);
    run_frame("kh1_single", 1'b0, 2, 2, 3);
    ready_gaps = 1'b1;
    run_frame("kh3_gaps", 1'b1, 3, 4, 4);
    waited = 0;
    while (frames_done < 3) begin
      waited++;
      if (waited > 5000) stop_run("the last frame never finished on the output");
      @(posedge aclk);
    end
    repeat (20) @(posedge aclk);
    $display("No errors");
    $finish;
  end

endmodule

// File: src.f
rtl/pixel_pkg.sv
rtl/pixel_frame_ctrl.sv
rtl/edge_line_ram.sv
rtl/window_shifter.sv
rtl/axis_pixels.sv
test/axis_pixels_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = axis_pixels_tb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
